//--- include/pwm_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes, register map and control bit positions of
// the multi-channel PWM generator. Include it in any
// file that needs a width, an address or a bit index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PWM_DEFS_SVH
`define PWM_DEFS_SVH

// Six counter channels, each with a complementary pair of pins
`define PWM_CHANNELS 6
`define PWM_OUTPUTS 12
`define PWM_COUNTER_WIDTH 16
`define PWM_REGISTER_WIDTH 32
`define PWM_ADDRESS_WIDTH 4
`define PWM_TB_DIV_WIDTH 3

// Register map, compare register of channel k lives at base plus k
`define PWM_ADDR_CTRL 0
`define PWM_ADDR_PERIOD 1
`define PWM_ADDR_COMPARE_BASE 2

// Fields of the control register
`define PWM_CTRL_TB_DIV_LSB 0
`define PWM_CTRL_TB_EN 3
`define PWM_CTRL_TB_EXT_EN 4
`define PWM_CTRL_RUN 5
`define PWM_CTRL_SYNC 6
`define PWM_CTRL_STOP_LSB 7

`endif

//--- design/pwm_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the PWM generator blocks. Refer to
// them by scoped name, for example
// pwm_pkg::counter_value_t
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "pwm_defs.svh"

package pwm_pkg;

    // Host side register word and address
    typedef logic [`PWM_REGISTER_WIDTH-1:0] register_word_t;
    typedef logic [`PWM_ADDRESS_WIDTH-1:0] register_address_t;

    // Counter, period and compare values all share one width
    typedef logic [`PWM_COUNTER_WIDTH-1:0] counter_value_t;

    // Exponent of the power-of-two clock divider
    typedef logic [`PWM_TB_DIV_WIDTH-1:0] timebase_divisor_t;

    // One bit per output pin, pin 2k is high side of channel k
    typedef logic [`PWM_OUTPUTS-1:0] pin_state_t;

    // Source of the counter tick
    typedef enum logic [1:0] {
        TIMEBASE_IDLE,
        TIMEBASE_INTERNAL,
        TIMEBASE_EXTERNAL
    } timebase_state_t;

endpackage

`default_nettype wire

//--- design/pwm_control_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Global control unit of the PWM generator. Holds the
// control, period and compare registers written by
// the host through a plain write strobe, serves the
// combinational read-back and hands the settings out
// to the timebase, the channels and the output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_control_unit (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         register_write,
    input  pwm_pkg::register_address_t  register_address,
    input  pwm_pkg::register_word_t     register_write_data,
    input  wire                         counter_status,
    output pwm_pkg::register_word_t     register_read_data,
    output pwm_pkg::timebase_divisor_t  timebase_divisor,
    output logic                        timebase_enable,
    output logic                        timebase_external_enable,
    output logic                        counter_run,
    output logic                        sync,
    output pwm_pkg::pin_state_t         stop_state,
    output pwm_pkg::counter_value_t     period,
    output pwm_pkg::counter_value_t     compare [0:`PWM_CHANNELS-1]
);

    pwm_pkg::register_word_t control_register;
    pwm_pkg::register_word_t period_register;
    pwm_pkg::register_word_t compare_register [0:`PWM_CHANNELS-1];

    // Set once a sync pulse went out, cleared when the host drops the bit
    logic sync_wait;

    // Host writes land in the register on the next rising edge
    always_ff @(posedge clock) begin
        if (!reset) begin
            control_register <= '0;
            period_register <= '0;
            for (int k = 0; k < `PWM_CHANNELS; k++) begin
                compare_register[k] <= '0;
            end
        end else if (register_write) begin
            if (register_address == pwm_pkg::register_address_t'(`PWM_ADDR_CTRL)) begin
                control_register <= register_write_data;
            end
            if (register_address == pwm_pkg::register_address_t'(`PWM_ADDR_PERIOD)) begin
                period_register <= register_write_data;
            end
            for (int k = 0; k < `PWM_CHANNELS; k++) begin
                if (register_address ==
                        pwm_pkg::register_address_t'(`PWM_ADDR_COMPARE_BASE + k)) begin
                    compare_register[k] <= register_write_data;
                end
            end
        end
    end

    // Read-back returns the stored word, anything unmapped reads as zero
    always_comb begin
        register_read_data = '0;
        if (register_address == pwm_pkg::register_address_t'(`PWM_ADDR_CTRL)) begin
            register_read_data = control_register;
        end
        if (register_address == pwm_pkg::register_address_t'(`PWM_ADDR_PERIOD)) begin
            register_read_data = period_register;
        end
        for (int k = 0; k < `PWM_CHANNELS; k++) begin
            if (register_address ==
                    pwm_pkg::register_address_t'(`PWM_ADDR_COMPARE_BASE + k)) begin
                register_read_data = compare_register[k];
            end
        end
    end

    // Settings that leave the unit one cycle after the write
    always_ff @(posedge clock) begin
        if (!reset) begin
            timebase_divisor <= '0;
            timebase_enable <= 1'b0;
            timebase_external_enable <= 1'b0;
            counter_run <= 1'b0;
            stop_state <= '0;
            sync <= 1'b0;
            sync_wait <= 1'b0;
        end else begin
            // A rising sync bit gives exactly one pulse, then we wait for it to clear
            if (!sync_wait) begin
                sync <= control_register[`PWM_CTRL_SYNC];
                sync_wait <= control_register[`PWM_CTRL_SYNC];
            end else begin
                sync <= 1'b0;
                if (!control_register[`PWM_CTRL_SYNC]) begin
                    sync_wait <= 1'b0;
                end
            end
            // The divisor must not move under running counters
            if (!counter_status) begin
                timebase_divisor <= control_register[`PWM_CTRL_TB_DIV_LSB +: `PWM_TB_DIV_WIDTH];
                timebase_enable <= control_register[`PWM_CTRL_TB_EN];
                timebase_external_enable <= control_register[`PWM_CTRL_TB_EXT_EN];
            end
            counter_run <= control_register[`PWM_CTRL_RUN];
            stop_state <= control_register[`PWM_CTRL_STOP_LSB +: `PWM_OUTPUTS];
        end
    end

    // Period and compare only use the low bits of their words
    assign period = period_register[`PWM_COUNTER_WIDTH-1:0];

    always_comb begin
        for (int k = 0; k < `PWM_CHANNELS; k++) begin
            compare[k] = compare_register[k][`PWM_COUNTER_WIDTH-1:0];
        end
    end

    // Sync is a single-cycle pulse however long the bit stays set
    sync_single_pulse: assert property (
        @(posedge clock) disable iff (!reset) sync |=> !sync
    );

endmodule

`default_nettype wire

//--- design/pwm_timebase.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counter tick generator. Produces a one-cycle tick
// either from a power-of-two clock divider or from a
// synchronized external tick input, as selected by
// the control unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_timebase (
    input  wire                         clock,
    input  wire                         reset,
    input  pwm_pkg::timebase_divisor_t  timebase_divisor,
    input  wire                         timebase_enable,
    input  wire                         timebase_external_enable,
    input  wire                         external_tick,
    output logic                        tick
);

    // Largest divisor exponent sets the prescaler width
    localparam int PRESCALER_WIDTH = 2 ** `PWM_TB_DIV_WIDTH - 1;

    pwm_pkg::timebase_state_t state;
    pwm_pkg::timebase_state_t next_state;
    logic [PRESCALER_WIDTH-1:0] prescaler;
    logic [PRESCALER_WIDTH-1:0] divisor_mask;
    logic [2:0] external_sync;

    // The external source also needs the timebase enable
    always_comb begin
        if (!timebase_enable) begin
            next_state = pwm_pkg::TIMEBASE_IDLE;
        end else if (timebase_external_enable) begin
            next_state = pwm_pkg::TIMEBASE_EXTERNAL;
        end else begin
            next_state = pwm_pkg::TIMEBASE_INTERNAL;
        end
    end

    // Low divisor bits all set marks the end of a divided period
    assign divisor_mask = PRESCALER_WIDTH'((1 << timebase_divisor) - 1);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= pwm_pkg::TIMEBASE_IDLE;
            prescaler <= '0;
            external_sync <= '0;
            tick <= 1'b0;
        end else begin
            state <= next_state;
            // Two synchronizer flops, the third keeps history for the edge
            external_sync <= {external_sync[1:0], external_tick};
            // Prescaler only runs while the machine sits in internal mode
            if (state == pwm_pkg::TIMEBASE_INTERNAL) begin
                prescaler <= prescaler + 1'b1;
            end else begin
                prescaler <= '0;
            end
            // The registered mode picks the source, and a move to idle cuts the tick off
            if (next_state == pwm_pkg::TIMEBASE_IDLE) begin
                tick <= 1'b0;
            end else begin
                case (state)
                    pwm_pkg::TIMEBASE_INTERNAL:
                        tick <= (prescaler & divisor_mask) == divisor_mask;
                    pwm_pkg::TIMEBASE_EXTERNAL:
                        tick <= external_sync[1] & ~external_sync[2];
                    default:
                        tick <= 1'b0;
                endcase
            end
        end
    end

    // Counters must never see a tick while the machine is idle
    no_tick_when_idle: assert property (
        @(posedge clock) disable iff (!reset) (state == pwm_pkg::TIMEBASE_IDLE) |-> !tick
    );

endmodule

`default_nettype wire

//--- design/pwm_counter_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One PWM channel. An up-counter advanced by the
// timebase tick wraps at the shared period, and its
// compare value sets the duty of a complementary,
// registered output pair
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_counter_channel (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      tick,
    input  wire                      counter_run,
    input  wire                      sync,
    input  pwm_pkg::counter_value_t  period,
    input  pwm_pkg::counter_value_t  compare,
    output logic                     pin_high,
    output logic                     pin_low,
    output logic                     counter_active
);

    pwm_pkg::counter_value_t counter;
    pwm_pkg::counter_value_t last_count;
    logic compare_match;

    // Value at which the counter wraps back to zero
    assign last_count = period - 1'b1;

    // High side is on while the count is below the compare value
    assign compare_match = counter < compare;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
        end else if (!counter_run || sync) begin
            // Stopping or a sync both restart the count from zero
            counter <= '0;
        end else if (tick) begin
            // A shrunken period still wraps instead of running on
            if (counter >= last_count) begin
                counter <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Output pair is registered one cycle behind the counter
    always_ff @(posedge clock) begin
        if (!reset) begin
            pin_high <= 1'b0;
            pin_low <= 1'b0;
        end else begin
            pin_high <= compare_match;
            pin_low <= ~compare_match;
        end
    end

    // Keeps the timebase settings frozen until this channel is at rest
    assign counter_active = (counter != '0) || counter_run;

    // With a steady period the count never reaches or passes it
    counter_below_period: assert property (
        @(posedge clock) disable iff (!reset)
        (period != '0 && counter < period && $stable(period)) |=> counter < period
    );

endmodule

`default_nettype wire

//--- design/pwm_output_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output stage of the PWM generator. Interleaves the
// channel pairs onto the pins and registers them, or
// drives the programmed stop state while the
// counters are not running
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_output_stage (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        counter_run,
    input  pwm_pkg::pin_state_t        stop_state,
    input  wire [`PWM_CHANNELS-1:0]    channel_high,
    input  wire [`PWM_CHANNELS-1:0]    channel_low,
    output pwm_pkg::pin_state_t        pwm_out
);

    pwm_pkg::pin_state_t channel_pins;

    // Even pins carry the high side, odd pins the low side
    always_comb begin
        for (int k = 0; k < `PWM_CHANNELS; k++) begin
            channel_pins[2*k] = channel_high[k];
            channel_pins[2*k+1] = channel_low[k];
        end
    end

    // Second register stage, so pins lag the counters by two cycles
    always_ff @(posedge clock) begin
        if (!reset) begin
            pwm_out <= '0;
        end else if (!counter_run) begin
            // Stopped counters hand the pins to the stop state
            pwm_out <= stop_state;
        end else begin
            pwm_out <= channel_pins;
        end
    end

endmodule

`default_nettype wire

//--- design/pwm_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the multi-channel PWM generator. A
// host programs it through write strobes, and it
// drives 12 output pins from 6 counter channels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_subsystem (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         register_write,
    input  pwm_pkg::register_address_t  register_address,
    input  pwm_pkg::register_word_t     register_write_data,
    input  wire                         external_tick,
    output pwm_pkg::register_word_t     register_read_data,
    output pwm_pkg::pin_state_t         pwm_out
);

    pwm_pkg::timebase_divisor_t timebase_divisor;
    logic timebase_enable;
    logic timebase_external_enable;
    logic counter_run;
    logic sync;
    logic tick;
    logic counter_status;
    pwm_pkg::pin_state_t stop_state;
    pwm_pkg::counter_value_t period;
    pwm_pkg::counter_value_t compare [0:`PWM_CHANNELS-1];
    logic [`PWM_CHANNELS-1:0] channel_high;
    logic [`PWM_CHANNELS-1:0] channel_low;
    logic [`PWM_CHANNELS-1:0] counter_active;

    // Any channel still busy holds the timebase settings
    assign counter_status = |counter_active;

    pwm_control_unit control_unit (
        .clock(clock),
        .reset(reset),
        .register_write(register_write),
        .register_address(register_address),
        .register_write_data(register_write_data),
        .counter_status(counter_status),
        .register_read_data(register_read_data),
        .timebase_divisor(timebase_divisor),
        .timebase_enable(timebase_enable),
        .timebase_external_enable(timebase_external_enable),
        .counter_run(counter_run),
        .sync(sync),
        .stop_state(stop_state),
        .period(period),
        .compare(compare)
    );

    pwm_timebase timebase (
        .clock(clock),
        .reset(reset),
        .timebase_divisor(timebase_divisor),
        .timebase_enable(timebase_enable),
        .timebase_external_enable(timebase_external_enable),
        .external_tick(external_tick),
        .tick(tick)
    );

    // All channels share tick, run, sync and period
    for (genvar k = 0; k < `PWM_CHANNELS; k++) begin : channel
        pwm_counter_channel counter_channel (
            .clock(clock),
            .reset(reset),
            .tick(tick),
            .counter_run(counter_run),
            .sync(sync),
            .period(period),
            .compare(compare[k]),
            .pin_high(channel_high[k]),
            .pin_low(channel_low[k]),
            .counter_active(counter_active[k])
        );
    end

    pwm_output_stage output_stage (
        .clock(clock),
        .reset(reset),
        .counter_run(counter_run),
        .stop_state(stop_state),
        .channel_high(channel_high),
        .channel_low(channel_low),
        .pwm_out(pwm_out)
    );

endmodule

`default_nettype wire

//--- tests/pwm_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench of the PWM generator. Programs
// the registers through the write strobe and checks
// read-back, stop state, duty, divisor gating, the
// external timebase and sync on the output pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_tb;

    // Slowest test needs well under a thousand cycles
    localparam int CYCLE_LIMIT = 20000;
    localparam int DUTY_PERIOD = 10;
    localparam int DUTY_PERIODS = 4;
    localparam int GATING_PERIOD = 16;
    localparam int EXTERNAL_PERIOD = 8;
    localparam int SYNC_PERIOD = 16;
    localparam logic [11:0] EVEN_PINS = 12'h555;

    logic clock;
    logic reset;
    logic register_write;
    pwm_pkg::register_address_t register_address;
    pwm_pkg::register_word_t register_write_data;
    logic external_tick;
    pwm_pkg::register_word_t register_read_data;
    pwm_pkg::pin_state_t pwm_out;

    int cycle_count;
    int error_count;
    int check_count;
    integer seed;

    pwm_subsystem UUT (
        .clock(clock),
        .reset(reset),
        .register_write(register_write),
        .register_address(register_address),
        .register_write_data(register_write_data),
        .external_tick(external_tick),
        .register_read_data(register_read_data),
        .pwm_out(pwm_out)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Ends a run that hangs somewhere in a wait loop
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string message);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s, expected %0h, got %0h",
                     $time, message, expected, actual);
        end
    endtask

    // One strobe cycle, driven on the falling edge
    task automatic write_register(input int address, input pwm_pkg::register_word_t data);
        @(negedge clock);
        register_write = 1'b1;
        register_address = pwm_pkg::register_address_t'(address);
        register_write_data = data;
        @(negedge clock);
        register_write = 1'b0;
    endtask

    // Read-back is combinational, so sample just after the address settles
    task automatic read_register(input int address, output pwm_pkg::register_word_t data);
        @(negedge clock);
        register_address = pwm_pkg::register_address_t'(address);
        #1 data = register_read_data;
    endtask

    function automatic pwm_pkg::register_word_t control_word(input int divisor,
        input logic enable, input logic external, input logic run, input logic sync_bit,
        input int stop);
        pwm_pkg::register_word_t word;
        word = '0;
        word[`PWM_CTRL_TB_DIV_LSB +: `PWM_TB_DIV_WIDTH] = divisor[`PWM_TB_DIV_WIDTH-1:0];
        word[`PWM_CTRL_TB_EN] = enable;
        word[`PWM_CTRL_TB_EXT_EN] = external;
        word[`PWM_CTRL_RUN] = run;
        word[`PWM_CTRL_SYNC] = sync_bit;
        word[`PWM_CTRL_STOP_LSB +: `PWM_OUTPUTS] = stop[`PWM_OUTPUTS-1:0];
        return word;
    endfunction

    // Clearing run lets the counters fall back to zero and go idle
    task automatic stop_counters;
        write_register(`PWM_ADDR_CTRL, '0);
        repeat (6) @(negedge clock);
    endtask

    // Returns on the falling clock edge where the pin first shows the new level
    task automatic wait_pin_edge(input int pin, input logic level);
        logic previous;
        logic current;
        previous = pwm_out[pin];
        current = previous;
        while (!(current == level && previous != level)) begin
            @(negedge clock);
            previous = current;
            current = pwm_out[pin];
        end
    endtask

    // The first rise may close a partial period, so time the next whole one
    task automatic measure_rise_interval(input int pin, output int cycles);
        int start;
        wait_pin_edge(pin, 1'b1);
        wait_pin_edge(pin, 1'b1);
        start = cycle_count;
        wait_pin_edge(pin, 1'b1);
        cycles = cycle_count - start;
    endtask

    // Long enough for the tick to pass the synchronizer and both pin registers
    task automatic pulse_external_tick;
        @(negedge clock);
        external_tick = 1'b1;
        repeat (3) @(negedge clock);
        external_tick = 1'b0;
        repeat (5) @(negedge clock);
    endtask

    task automatic readback_test;
        pwm_pkg::register_word_t written [0:`PWM_CHANNELS+1];
        pwm_pkg::register_word_t data;
        // Control goes last, so random run bits never see the period change
        for (int a = `PWM_CHANNELS + 1; a >= 0; a--) begin
            written[a] = $random(seed);
            write_register(a, written[a]);
        end
        for (int a = 0; a < `PWM_CHANNELS + 2; a++) begin
            read_register(a, data);
            check_value(data, written[a], $sformatf("read-back of register %0d", a));
        end
        for (int a = `PWM_CHANNELS + 2; a < 16; a++) begin
            read_register(a, data);
            check_value(data, 0, $sformatf("unmapped register %0d", a));
        end
        stop_counters();
    endtask

    task automatic stop_state_test;
        int stop;
        repeat (2) begin
            stop = $random(seed) & 12'hfff;
            write_register(`PWM_ADDR_CTRL, control_word(0, 1'b0, 1'b0, 1'b0, 1'b0, stop));
            repeat (4) @(negedge clock);
            check_value(pwm_out, stop, "stop state on the pins");
        end
        stop_counters();
    endtask

    task automatic duty_cycle_test;
        int compare_value [0:`PWM_CHANNELS-1];
        int high_cycles [0:`PWM_CHANNELS-1];
        int inverse_errors;
        write_register(`PWM_ADDR_PERIOD, DUTY_PERIOD);
        for (int k = 0; k < `PWM_CHANNELS; k++) begin
            compare_value[k] = {$random(seed)} % DUTY_PERIOD;
            high_cycles[k] = 0;
            write_register(`PWM_ADDR_COMPARE_BASE + k, compare_value[k]);
        end
        inverse_errors = 0;
        write_register(`PWM_ADDR_CTRL, control_word(0, 1'b1, 1'b0, 1'b1, 1'b0, 0));
        repeat (2 * DUTY_PERIOD) @(negedge clock);
        // With divisor 0 every clock is a tick, so any window of whole periods works
        repeat (DUTY_PERIODS * DUTY_PERIOD) begin
            @(negedge clock);
            for (int k = 0; k < `PWM_CHANNELS; k++) begin
                if (pwm_out[2*k]) high_cycles[k]++;
                if (pwm_out[2*k+1] === pwm_out[2*k]) inverse_errors++;
            end
        end
        for (int k = 0; k < `PWM_CHANNELS; k++) begin
            check_value(high_cycles[k], compare_value[k] * DUTY_PERIODS,
                        $sformatf("high cycles of pin %0d", 2 * k));
        end
        check_value(inverse_errors, 0, "cycles where a low pin equals its high pin");
        stop_counters();
    endtask

    task automatic divisor_gating_test;
        int interval;
        write_register(`PWM_ADDR_PERIOD, GATING_PERIOD);
        write_register(`PWM_ADDR_COMPARE_BASE, GATING_PERIOD / 2);
        write_register(`PWM_ADDR_CTRL, control_word(2, 1'b1, 1'b0, 1'b1, 1'b0, 0));
        measure_rise_interval(0, interval);
        check_value(interval, 4 * GATING_PERIOD, "pin 0 period with divisor 2");
        // Running counters hold the old divisor
        write_register(`PWM_ADDR_CTRL, control_word(0, 1'b1, 1'b0, 1'b1, 1'b0, 0));
        measure_rise_interval(0, interval);
        check_value(interval, 4 * GATING_PERIOD, "pin 0 period after a divisor write");
        write_register(`PWM_ADDR_CTRL, control_word(0, 1'b1, 1'b0, 1'b0, 1'b0, 0));
        repeat (6) @(negedge clock);
        write_register(`PWM_ADDR_CTRL, control_word(0, 1'b1, 1'b0, 1'b1, 1'b0, 0));
        measure_rise_interval(0, interval);
        check_value(interval, GATING_PERIOD, "pin 0 period once the counters went idle");
        stop_counters();
    endtask

    task automatic external_timebase_test;
        int pulses;
        int intervals;
        logic seen_rise;
        logic previous;
        write_register(`PWM_ADDR_PERIOD, EXTERNAL_PERIOD);
        write_register(`PWM_ADDR_COMPARE_BASE, EXTERNAL_PERIOD / 2);
        write_register(`PWM_ADDR_CTRL, control_word(0, 1'b1, 1'b1, 1'b1, 1'b0, 0));
        // Pin 0 is already high at count zero, so the first rise is a real wrap
        repeat (4) @(negedge clock);
        pulses = 0;
        intervals = 0;
        seen_rise = 1'b0;
        previous = pwm_out[0];
        repeat (4 * EXTERNAL_PERIOD + 2) begin
            pulse_external_tick();
            pulses++;
            if (pwm_out[0] && !previous) begin
                if (seen_rise) begin
                    check_value(pulses, EXTERNAL_PERIOD, "external ticks per output period");
                    intervals++;
                end
                seen_rise = 1'b1;
                pulses = 0;
            end
            previous = pwm_out[0];
        end
        if (intervals < 2) begin
            error_count++;
            $display("Pin 0 did not complete two periods on the external timebase");
        end
        stop_counters();
    endtask

    task automatic sync_test;
        pwm_pkg::register_word_t running;
        int latency;
        int early_highs;
        write_register(`PWM_ADDR_PERIOD, SYNC_PERIOD);
        for (int k = 0; k < `PWM_CHANNELS; k++) begin
            write_register(`PWM_ADDR_COMPARE_BASE + k, 3 + 2 * k);
        end
        running = control_word(0, 1'b1, 1'b0, 1'b1, 1'b0, 0);
        write_register(`PWM_ADDR_CTRL, running);
        // Pin 0 has the smallest compare, so after its fall no pin rises before the wrap
        wait_pin_edge(0, 1'b0);
        write_register(`PWM_ADDR_CTRL, running | (1 << `PWM_CTRL_SYNC));
        latency = 1;
        @(negedge clock);
        while (!pwm_out[0] && latency < 2 * SYNC_PERIOD) begin
            @(negedge clock);
            latency++;
        end
        // Sync pulse one cycle after the write, then two register stages to the pins
        check_value(latency, 4, "cycles from sync write to pin 0 high");
        check_value(pwm_out & EVEN_PINS, EVEN_PINS, "high pins after sync");
        check_value(pwm_out & ~EVEN_PINS, 0, "low pins after sync");
        wait_pin_edge(0, 1'b0);
        write_register(`PWM_ADDR_CTRL, running | (1 << `PWM_CTRL_SYNC));
        early_highs = 0;
        repeat (6) begin
            @(negedge clock);
            if (pwm_out[0]) early_highs++;
        end
        check_value(early_highs, 0, "pin 0 high again while the sync bit stayed set");
        write_register(`PWM_ADDR_CTRL, running);
        stop_counters();
    endtask

    initial begin
        seed = 32'h62c1538a;
        error_count = 0;
        check_count = 0;
        reset = 1'b0;
        register_write = 1'b0;
        register_address = '0;
        register_write_data = '0;
        external_tick = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b1;
        readback_test();
        stop_state_test();
        duty_cycle_test();
        divisor_gating_test();
        external_timebase_test();
        sync_test();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
design/pwm_pkg.sv
design/pwm_control_unit.sv
design/pwm_timebase.sv
design/pwm_counter_channel.sv
design/pwm_output_stage.sv
design/pwm_subsystem.sv
tests/pwm_tb.sv

//--- Makefile
# Verilator build and run of the PWM generator testbench
TOP = pwm_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir
